//--- sources.f
+incdir+.
llmint_pkg.sv
scatter_threshold.sv
fixed_linear.sv
gather.sv
llmint.sv
llmint_tb.sv

//--- llmint_tb.sv
`include "llmint_consts.svh"

module llmint_tb import llmint_pkg::*;;

  localparam int NUM_ENTRIES = 10;
  localparam int TIMEOUT = 50;

  logic      clk;
  logic      rst;
  hi_elem_t  data_in [`LLM_DIM-1:0];
  logic      data_in_valid;
  logic      data_in_ready;
  hi_elem_t  weights [`LLM_DIM*`LLM_DIM-1:0];
  logic      weight_valid;
  logic      weight_ready;
  lo_elem_t  q_weights [`LLM_DIM*`LLM_DIM-1:0];
  logic      q_weight_valid;
  logic      q_weight_ready;
  out_elem_t data_out [`LLM_DIM-1:0];
  logic      data_out_valid;
  logic      data_out_ready;
  hi_elem_t  high_precision_masked [`LLM_DIM-1:0];
  lo_elem_t  low_precision_masked  [`LLM_DIM-1:0];

  // stimulus table: vector, reload flag, output stall length
  hi_elem_t  tbl_vec [0:NUM_ENTRIES-1][`LLM_DIM-1:0];
  logic      tbl_reload [0:NUM_ENTRIES-1];
  int        tbl_bp [0:NUM_ENTRIES-1];

  // model copies of the loaded matrices
  longint    w_hi [`LLM_DIM*`LLM_DIM];
  longint    w_lo [`LLM_DIM*`LLM_DIM];
  longint    exp_q [$];
  integer    seed;
  logic      weights_loaded;
  int        n_accepted;
  int        n_delivered;
  logic      stalled;
  out_elem_t held [`LLM_DIM-1:0];

  llmint i_dut (
    .clk                   (clk),
    .rst                   (rst),
    .data_in               (data_in),
    .data_in_valid         (data_in_valid),
    .data_in_ready         (data_in_ready),
    .weights               (weights),
    .weight_valid          (weight_valid),
    .weight_ready          (weight_ready),
    .q_weights             (q_weights),
    .q_weight_valid        (q_weight_valid),
    .q_weight_ready        (q_weight_ready),
    .data_out              (data_out),
    .data_out_valid        (data_out_valid),
    .data_out_ready        (data_out_ready),
    .high_precision_masked (high_precision_masked),
    .low_precision_masked  (low_precision_masked)
  );

  always #10 clk = ~clk;

  task automatic check_val(input string name, input logic signed [63:0] expected,
                           input logic signed [63:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %h got %h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic abort_on_stall(input string what);
    $display("no handshake on %s within %0d cycles", what, TIMEOUT);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic set_entry(input int idx, input int a, input int b, input int c, input int d,
                           input logic reload, input int bp);
    tbl_vec[idx][0] = hi_elem_t'(a);
    tbl_vec[idx][1] = hi_elem_t'(b);
    tbl_vec[idx][2] = hi_elem_t'(c);
    tbl_vec[idx][3] = hi_elem_t'(d);
    tbl_reload[idx] = reload;
    tbl_bp[idx] = bp;
  endtask

  // slot rule on the input, then both products summed per row
  task automatic model_vector(input hi_elem_t v [`LLM_DIM-1:0],
                              output hi_elem_t hm [`LLM_DIM-1:0],
                              output lo_elem_t lm [`LLM_DIM-1:0],
                              output longint sums [`LLM_DIM-1:0]);
    int slots;
    longint mag;
    longint lo_val;
    slots = 0;
    for (int j = 0; j < `LLM_DIM; j++) begin
      mag = (v[j] < 0) ? -longint'(v[j]) : longint'(v[j]);
      if (mag > `LLM_THRESHOLD && slots < `LLM_HIGH_SLOTS) begin
        hm[j] = v[j];
        lm[j] = '0;
        slots++;
      end else begin
        hm[j] = '0;
        lo_val = longint'(v[j]);
        if (lo_val > 127) lo_val = 127;
        if (lo_val < -128) lo_val = -128;
        lm[j] = lo_elem_t'(lo_val);
      end
    end
    for (int i = 0; i < `LLM_DIM; i++) begin
      sums[i] = 0;
      for (int j = 0; j < `LLM_DIM; j++) begin
        sums[i] += longint'(hm[j]) * w_hi[i*`LLM_DIM+j] + longint'(lm[j]) * w_lo[i*`LLM_DIM+j];
      end
    end
  endtask

  task automatic load_weights();
    int waited;
    for (int k = 0; k < `LLM_DIM*`LLM_DIM; k++) begin
      w_hi[k] = $random(seed) % 1001;
      w_lo[k] = $random(seed) % 101;
      weights[k] = hi_elem_t'(w_hi[k]);
      q_weights[k] = lo_elem_t'(w_lo[k]);
    end
    weight_valid = 1'b1;
    q_weight_valid = 1'b1;
    waited = 0;
    @(negedge clk);
    while (!(weight_ready && q_weight_ready)) begin
      waited++;
      if (waited > TIMEOUT) abort_on_stall("weight_ready and q_weight_ready");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    weight_valid = 1'b0;
    q_weight_valid = 1'b0;
    weights_loaded = 1'b1;
  endtask

  task automatic send_vector(input int idx);
    hi_elem_t hm [`LLM_DIM-1:0];
    lo_elem_t lm [`LLM_DIM-1:0];
    longint sums [`LLM_DIM-1:0];
    int waited;
    model_vector(tbl_vec[idx], hm, lm, sums);
    data_in = tbl_vec[idx];
    data_in_valid = 1'b1;
    @(negedge clk);
    for (int i = 0; i < `LLM_DIM; i++) begin
      check_val($sformatf("high_precision_masked[%0d]", i), hm[i], high_precision_masked[i]);
      check_val($sformatf("low_precision_masked[%0d]", i), lm[i], low_precision_masked[i]);
    end
    waited = 0;
    while (!data_in_ready) begin
      waited++;
      if (waited > TIMEOUT) abort_on_stall("data_in_ready");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    data_in_valid = 1'b0;
    for (int i = 0; i < `LLM_DIM; i++) begin
      exp_q.push_back(sums[i]);
    end
  endtask

  // always steps at least one edge so a stalled older result is skipped
  task automatic wait_output(output int edges);
    edges = 0;
    do begin
      @(posedge clk);
      #1;
      edges++;
      if (edges > TIMEOUT) abort_on_stall("data_out_valid");
    end while (!data_out_valid);
  endtask

  task automatic check_output();
    for (int i = 0; i < `LLM_DIM; i++) begin
      check_val("expected results left", 1, exp_q.size() > 0);
      check_val($sformatf("data_out[%0d]", i), exp_q.pop_front(), data_out[i]);
    end
  endtask

  // ready, stability and in-flight count, sampled away from the drive time
  always @(negedge clk) begin
    if (!rst) begin
      if (stalled) begin
        check_val("data_out_valid", 1, data_out_valid);
        for (int i = 0; i < `LLM_DIM; i++) begin
          check_val($sformatf("data_out[%0d]", i), held[i], data_out[i]);
        end
      end
      check_val("vectors in flight", 1, (n_accepted - n_delivered) <= 2);
      check_val("data_in_ready",
                weights_loaded && !((n_accepted - n_delivered) == 2 && !data_out_ready),
                data_in_ready);
      stalled = data_out_valid && !data_out_ready;
      held = data_out;
      if (data_in_valid && data_in_ready) n_accepted++;
      if (data_out_valid && data_out_ready) n_delivered++;
    end
  end

  initial begin
    int idx;
    int edges;
    clk = 1'b0;
    rst = 1'b1;
    seed = 18456;
    data_in = '{default: '0};
    data_in_valid = 1'b0;
    weights = '{default: '0};
    weight_valid = 1'b0;
    q_weights = '{default: '0};
    q_weight_valid = 1'b0;
    data_out_ready = 1'b1;
    weights_loaded = 1'b0;
    n_accepted = 0;
    n_delivered = 0;
    stalled = 1'b0;

    // no outliers, two, negatives, overflow, extremes, then stalls and reloads
    set_entry(0, 1, -2, 3, 4, 1'b1, 0);
    set_entry(1, 100, -3, -50, 2, 1'b0, 0);
    set_entry(2, -7, 5, -300, 6, 1'b0, 0);
    set_entry(3, 200, -200, 500, -900, 1'b0, 0);
    set_entry(4, 32767, -32768, 7, -7, 1'b1, 0);
    set_entry(5, 10, 0, 0, -10, 1'b0, 5);
    set_entry(6, -1, 8, 120, -130, 1'b0, 0);
    set_entry(7, 3, 3, 3, 3, 1'b1, 0);
    set_entry(8, -1000, 1, -1, 1000, 1'b0, 3);
    set_entry(9, 6, -6, 7, -129, 1'b0, 0);

    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_val("data_out_valid", 0, data_out_valid);
    check_val("data_in_ready", 0, data_in_ready);
    check_val("weight_ready", 1, weight_ready);
    check_val("q_weight_ready", 1, q_weight_ready);
    @(posedge clk);
    #1;

    idx = 0;
    while (idx < NUM_ENTRIES) begin
      if (tbl_reload[idx]) load_weights();
      if (tbl_bp[idx] == 0) begin
        send_vector(idx);
        wait_output(edges);
        // the output seen after an edge transfers on the following edge
        check_val("latency_edges", 2, edges + 1);
        check_output();
        idx++;
      end else begin
        // the previous output leaves first
        @(posedge clk);
        #1;
        // two vectors enter behind a stalled output
        data_out_ready = 1'b0;
        send_vector(idx);
        send_vector(idx + 1);
        wait_output(edges);
        repeat (tbl_bp[idx]) @(posedge clk);
        #1;
        check_output();
        data_out_ready = 1'b1;
        wait_output(edges);
        check_output();
        idx += 2;
      end
    end

    @(posedge clk);
    #1;
    check_val("delivered vectors", NUM_ENTRIES, n_delivered);
    check_val("accepted vectors", NUM_ENTRIES, n_accepted);
    check_val("results left over", 0, exp_q.size());
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- llmint.sv
`include "llmint_consts.svh"

module llmint import llmint_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  input  hi_elem_t  data_in [`LLM_DIM-1:0],
  input  logic      data_in_valid,
  output logic      data_in_ready,

  input  hi_elem_t  weights [`LLM_DIM*`LLM_DIM-1:0],
  input  logic      weight_valid,
  output logic      weight_ready,

  input  lo_elem_t  q_weights [`LLM_DIM*`LLM_DIM-1:0],
  input  logic      q_weight_valid,
  output logic      q_weight_ready,

  output out_elem_t data_out [`LLM_DIM-1:0],
  output logic      data_out_valid,
  input  logic      data_out_ready,

  output hi_elem_t  high_precision_masked [`LLM_DIM-1:0],
  output lo_elem_t  low_precision_masked  [`LLM_DIM-1:0]
);

  logic    hi_in_ready;
  logic    lo_in_ready;
  logic    unit_in_valid;
  hi_acc_t hi_result [`LLM_DIM-1:0];
  logic    hi_result_valid;
  lo_acc_t lo_result [`LLM_DIM-1:0];
  logic    lo_result_valid;
  logic    gather_ready;

  // a vector enters only when both paths can take it together
  assign data_in_ready = hi_in_ready && lo_in_ready;
  assign unit_in_valid = data_in_valid && data_in_ready;

  scatter_threshold i_scatter (
    .data_in               (data_in),
    .high_precision_masked (high_precision_masked),
    .low_precision_masked  (low_precision_masked)
  );

  fixed_linear #(
    .elem_t (hi_elem_t),
    .acc_t  (hi_acc_t)
  ) i_high_linear (
    .clk           (clk),
    .rst           (rst),
    .data_in       (high_precision_masked),
    .data_in_valid (unit_in_valid),
    .data_in_ready (hi_in_ready),
    .weight        (weights),
    .weight_valid  (weight_valid),
    .weight_ready  (weight_ready),
    .result        (hi_result),
    .result_valid  (hi_result_valid),
    .result_ready  (gather_ready)
  );

  fixed_linear #(
    .elem_t (lo_elem_t),
    .acc_t  (lo_acc_t)
  ) i_low_linear (
    .clk           (clk),
    .rst           (rst),
    .data_in       (low_precision_masked),
    .data_in_valid (unit_in_valid),
    .data_in_ready (lo_in_ready),
    .weight        (q_weights),
    .weight_valid  (q_weight_valid),
    .weight_ready  (q_weight_ready),
    .result        (lo_result),
    .result_valid  (lo_result_valid),
    .result_ready  (gather_ready)
  );

  gather i_gather (
    .clk            (clk),
    .rst            (rst),
    .high_result    (hi_result),
    .high_valid     (hi_result_valid),
    .low_result     (lo_result),
    .low_valid      (lo_result_valid),
    .in_ready       (gather_ready),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

endmodule

//--- gather.sv
`include "llmint_consts.svh"

module gather import llmint_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  input  hi_acc_t   high_result [`LLM_DIM-1:0],
  input  logic      high_valid,
  input  lo_acc_t   low_result  [`LLM_DIM-1:0],
  input  logic      low_valid,
  output logic      in_ready,

  output out_elem_t data_out [`LLM_DIM-1:0],
  output logic      data_out_valid,
  input  logic      data_out_ready
);

  logic take;

  // one register stage, refillable in the cycle it drains
  assign in_ready = !data_out_valid || data_out_ready;
  assign take     = high_valid && low_valid && in_ready;

  // low accumulator is sign extended before the add
  always_ff @(posedge clk) begin
    if (take) begin
      for (int i = 0; i < `LLM_DIM; i++) begin
        data_out[i] <= out_elem_t'(high_result[i]) + out_elem_t'(low_result[i]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      data_out_valid <= 1'b0;
    end else if (take) begin
      data_out_valid <= 1'b1;
    end else if (data_out_ready) begin
      data_out_valid <= 1'b0;
    end
  end

  // both linear units run in lockstep off the shared input handshake
  a_lockstep : assert property (
    @(posedge clk) disable iff (rst)
    high_valid == low_valid
  );

endmodule

//--- fixed_linear.sv
`include "llmint_consts.svh"

module fixed_linear import llmint_pkg::*; #(
  parameter type elem_t = hi_elem_t,
  parameter type acc_t  = hi_acc_t
) (
  input  logic  clk,
  input  logic  rst,

  input  elem_t data_in [`LLM_DIM-1:0],
  input  logic  data_in_valid,
  output logic  data_in_ready,

  input  elem_t weight [`LLM_DIM*`LLM_DIM-1:0],
  input  logic  weight_valid,
  output logic  weight_ready,

  output acc_t  result [`LLM_DIM-1:0],
  output logic  result_valid,
  input  logic  result_ready
);

  elem_t weight_bank [`LLM_DIM*`LLM_DIM-1:0];
  logic  loaded;
  acc_t  row_sum [`LLM_DIM-1:0];
  logic  data_fire;
  logic  weight_fire;

  // weights may only change when nothing computed from them is waiting
  assign weight_ready = !result_valid;

  // accept a new vector if the output slot is free or drains this cycle
  assign data_in_ready = loaded && (!result_valid || result_ready);

  assign data_fire   = data_in_valid && data_in_ready;
  assign weight_fire = weight_valid && weight_ready;

  always_ff @(posedge clk) begin
    if (weight_fire) begin
      weight_bank <= weight;
    end
  end

  // row i of the bank dotted with the input vector
  always_comb begin
    for (int i = 0; i < `LLM_DIM; i++) begin
      row_sum[i] = '0;
      for (int j = 0; j < `LLM_DIM; j++) begin
        row_sum[i] += acc_t'(data_in[j]) * acc_t'(weight_bank[i*`LLM_DIM+j]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (data_fire) begin
      result <= row_sum;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      loaded       <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      if (weight_fire) begin
        loaded <= 1'b1;
      end
      if (data_fire) begin
        result_valid <= 1'b1;
      end else if (result_ready) begin
        result_valid <= 1'b0;
      end
    end
  end

  // a stalled result must not move until the consumer takes it
  for (genvar i = 0; i < `LLM_DIM; i++) begin : g_hold
    a_result_hold : assert property (
      @(posedge clk) disable iff (rst)
      result_valid && !result_ready |=> result_valid && $stable(result[i])
    );
  end

  // the bank behind a pending result is never replaced
  for (genvar k = 0; k < `LLM_DIM*`LLM_DIM; k++) begin : g_bank
    a_no_reload_pending : assert property (
      @(posedge clk) disable iff (rst)
      result_valid |=> $stable(weight_bank[k])
    );
  end

endmodule

//--- scatter_threshold.sv
`include "llmint_consts.svh"

module scatter_threshold import llmint_pkg::*; (
  input  hi_elem_t data_in               [`LLM_DIM-1:0],
  output hi_elem_t high_precision_masked [`LLM_DIM-1:0],
  output lo_elem_t low_precision_masked  [`LLM_DIM-1:0]
);

  localparam hi_elem_t THRESH = hi_elem_t'(`LLM_THRESHOLD);
  localparam hi_elem_t LO_MAX = 127;
  localparam hi_elem_t LO_MIN = -128;

  logic [`LLM_DIM-1:0] is_outlier;

  // saturate a full precision value into int8
  function automatic lo_elem_t clamp_int8(input hi_elem_t x);
    if (x > LO_MAX) begin
      return lo_elem_t'(LO_MAX);
    end else if (x < LO_MIN) begin
      return lo_elem_t'(LO_MIN);
    end
    return lo_elem_t'(x);
  endfunction

  // |x| > threshold, written as two signed compares so -32768 is safe
  for (genvar i = 0; i < `LLM_DIM; i++) begin : g_outlier
    assign is_outlier[i] = (data_in[i] > THRESH) || (data_in[i] < -THRESH);
  end

  // lowest indices win the high slots, later outliers fall back to int8
  always_comb begin : split
    int used;
    used = 0;
    for (int i = 0; i < `LLM_DIM; i++) begin
      high_precision_masked[i] = '0;
      low_precision_masked[i] = '0;
      if (is_outlier[i] && (used < `LLM_HIGH_SLOTS)) begin
        high_precision_masked[i] = data_in[i];
        used++;
      end else begin
        low_precision_masked[i] = clamp_int8(data_in[i]);
      end
    end
  end

endmodule

//--- llmint_pkg.sv
`include "llmint_consts.svh"

package llmint_pkg;

  // full precision path
  typedef logic signed [`LLM_ORIG_W-1:0] hi_elem_t;
  typedef logic signed [`LLM_HI_ACC_W-1:0] hi_acc_t;

  // int8 path
  typedef logic signed [`LLM_RED_W-1:0] lo_elem_t;
  typedef logic signed [`LLM_LO_ACC_W-1:0] lo_acc_t;

  // sum of both paths keeps the full high accumulator width
  typedef logic signed [`LLM_HI_ACC_W-1:0] out_elem_t;

endpackage

//--- llmint_consts.svh
`ifndef LLMINT_CONSTS_SVH
`define LLMINT_CONSTS_SVH

// element widths of the two paths
`define LLM_ORIG_W 16
`define LLM_RED_W 8

// vector length, also the side of the square weight matrix
`define LLM_DIM 4

// outlier selection
`define LLM_HIGH_SLOTS 2
`define LLM_THRESHOLD 6

// a full dot product grows by the product width plus log2 of the length
`define LLM_HI_ACC_W (2 * `LLM_ORIG_W + $clog2(`LLM_DIM))
`define LLM_LO_ACC_W (2 * `LLM_RED_W + $clog2(`LLM_DIM))

`endif
